// File: hw/tc_pkg.sv
`default_nettype none

package tc_pkg;

    typedef enum logic [1:0] {
        FP32 = 2'd0,
        FP16 = 2'd1,
        INT8 = 2'd2,
        INT4 = 2'd3
    } dtype_t;

    typedef enum logic [1:0] {
        M32K16N8  = 2'd0,
        M16K16N16 = 2'd1,
        M8K16N32  = 2'd2
    } shape_t;

    typedef enum logic [1:0] {
        MAT_A = 2'd0,
        MAT_B = 2'd1,
        MAT_C = 2'd2
    } mat_t;

    typedef struct packed {
        shape_t shape;
        dtype_t dtype;
        logic   mixed;  // Mixed precision accumulate
    } job_t;

    typedef struct packed {
        mat_t        mat;
        logic [31:0] base;
        logic [5:0]  burst_num;   // Bursts minus one
        logic [2:0]  burst_size;  // log2 bytes per beat
    } rd_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;    // Beats minus one
        logic [2:0]  size;
        logic [1:0]  burst;
    } wr_req_t;

    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        LOAD_C     = 4'd1,
        LOAD_A     = 4'd2,
        LOAD_B     = 4'd3,
        SYSTOLIC   = 4'd4,
        ACCUMULATE = 4'd5,
        WAIT_WRITE = 4'd6,
        WRITE_BACK = 4'd7,
        FINISH     = 4'd8
    } tc_state_t;

    localparam logic [31:0] BASE_C  = 32'h0001_0000;
    localparam logic [31:0] BASE_A  = 32'h0010_0000;
    localparam logic [31:0] BASE_B  = 32'h0100_0000;
    localparam logic [31:0] WB_ADDR = 32'h0000_0000;

    localparam int CNT_W = 7;

    localparam logic [CNT_W-1:0] SYSTOLIC_FP32     = 7'd64;
    localparam logic [CNT_W-1:0] SYSTOLIC_FP16     = 7'd64;
    localparam logic [CNT_W-1:0] SYSTOLIC_INT8     = 7'd16;
    localparam logic [CNT_W-1:0] SYSTOLIC_INT4     = 7'd8;
    localparam logic [CNT_W-1:0] WAIT_WRITE_CYCLES = 7'd10;

    localparam logic [7:0] WB_LEN_FULL  = 8'd255;
    localparam logic [7:0] WB_LEN_MIXED = 8'd127;
    localparam logic [2:0] WB_SIZE_WORD = 3'd2;  // 4 bytes per beat
    localparam logic [1:0] BURST_INCR   = 2'd1;

endpackage

`default_nettype wire

// File: hw/burst_table.sv
`timescale 1ns/1ps
`default_nettype none

module burst_table (
    input  tc_pkg::mat_t    mat,
    input  tc_pkg::job_t    job,
    output tc_pkg::rd_req_t req
);
    import tc_pkg::*;

    logic [5:0] a_top;  // FP32 burst count of A for this shape
    logic [2:0] narrow; // 5 for FP32 down to 2 for INT4

    assign narrow = 3'd5 - {1'b0, job.dtype};

    always_comb begin
        case (job.shape)
            M32K16N8:  a_top = 6'd63;
            M16K16N16: a_top = 6'd31;
            default:   a_top = 6'd15;
        endcase
    end

    always_comb begin
        req.mat = mat;
        case (mat)
            MAT_C: begin
                req.base      = BASE_C;
                req.burst_num = 6'd31;
                if (job.dtype == FP16 && job.mixed)
                    req.burst_size = 3'd5;  // C kept at FP32 width
                else
                    req.burst_size = narrow;
            end
            MAT_A: begin
                // A always moves full 32 byte beats, fewer of them for narrow types
                req.base       = BASE_A;
                req.burst_num  = a_top >> job.dtype;
                req.burst_size = 3'd5;
            end
            default: begin
                req.base = BASE_B;
                case (job.shape)
                    M32K16N8: begin
                        req.burst_num  = 6'd15;
                        req.burst_size = narrow;
                    end
                    M16K16N16: begin
                        req.burst_num  = (job.dtype == FP32) ? 6'd31 : 6'd15;
                        req.burst_size = (job.dtype == FP32) ? 3'd5 : narrow + 3'd1;
                    end
                    default: begin
                        case (job.dtype)
                            FP32:    req.burst_num = 6'd63;
                            FP16:    req.burst_num = 6'd31;
                            default: req.burst_num = 6'd15;
                        endcase
                        req.burst_size = (job.dtype == INT4) ? 3'd4 : 3'd5;
                    end
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rd_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module rd_issuer (
    input  wire             clk,
    input  wire             rst,
    input  wire             load_go,
    input  tc_pkg::mat_t    load_mat,
    input  tc_pkg::job_t    job,
    output logic            load_done,
    output tc_pkg::rd_req_t rd_req,
    output logic            rd_valid,
    input  wire             rd_ready,
    input  wire             rd_finish
);
    import tc_pkg::*;

    rd_req_t tbl_req;
    logic    in_flight; // Accepted, burst still running

    burst_table i_burst_table (
        .mat (load_mat),
        .job (job),
        .req (tbl_req)
    );

    always_ff @(posedge clk) begin
        if (load_go)
            rd_req <= tbl_req;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid  <= 1'b0;
            in_flight <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (load_go) begin
                rd_valid <= 1'b1;
            end else if (rd_valid && rd_ready) begin
                rd_valid  <= 1'b0;
                in_flight <= 1'b1;
            end
            // Finish before the handshake is not ours
            if (in_flight && rd_finish) begin
                in_flight <= 1'b0;
                load_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/wb_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module wb_issuer (
    input  wire             clk,
    input  wire             rst,
    input  wire             wb_go,
    input  tc_pkg::job_t    job,
    output logic            wb_done,
    output tc_pkg::wr_req_t aw,
    output logic            aw_valid,
    input  wire             aw_ready,
    input  wire             b_valid,
    output logic            b_ready
);
    import tc_pkg::*;

    wr_req_t wr_req;

    always_comb begin
        wr_req.addr  = WB_ADDR;
        wr_req.len   = job.mixed ? WB_LEN_MIXED : WB_LEN_FULL;
        wr_req.size  = WB_SIZE_WORD;
        wr_req.burst = BURST_INCR;
    end

    always_ff @(posedge clk) begin
        if (wb_go)
            aw <= wr_req;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_valid <= 1'b0;
            b_ready  <= 1'b0;
            wb_done  <= 1'b0;
        end else begin
            wb_done <= 1'b0;
            if (wb_go) begin
                aw_valid <= 1'b1;
            end else if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
                b_ready  <= 1'b1;  // Address taken, now wait for response
            end
            if (b_ready && b_valid) begin
                b_ready <= 1'b0;
                wb_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/tc_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module tc_scheduler (
    input  wire          clk,
    input  wire          rst,
    input  wire          start,
    input  tc_pkg::job_t job_in,
    output logic         busy,
    output logic         done,
    output tc_pkg::job_t job,
    output logic         load_go,
    output tc_pkg::mat_t load_mat,
    input  wire          load_done,
    output logic         wb_go,
    input  wire          wb_done
);
    import tc_pkg::*;

    tc_state_t        state;
    logic             kick;  // First cycle of LOAD_C
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] systolic_time;

    always_comb begin
        case (job.dtype)
            FP32:    systolic_time = SYSTOLIC_FP32;
            FP16:    systolic_time = SYSTOLIC_FP16;
            INT8:    systolic_time = SYSTOLIC_INT8;
            default: systolic_time = SYSTOLIC_INT4;
        endcase
    end

    // Next load starts in the cycle the previous one reports done
    assign load_go = kick || (load_done && (state == LOAD_C || state == LOAD_A));

    always_comb begin
        if (state == LOAD_C)
            load_mat = kick ? MAT_C : MAT_A;
        else
            load_mat = MAT_B;
    end

    // Fires as WRITE_BACK is entered
    assign wb_go = (state == SYSTOLIC && cnt == '0 && job.dtype != INT4)
                || (state == WAIT_WRITE && cnt == '0);

    assign busy = (state != IDLE);
    assign done = (state == FINISH);

    always_ff @(posedge clk) begin
        if (state == IDLE && start)
            job <= job_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            kick  <= 1'b0;
            cnt   <= '0;
        end else begin
            kick <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        kick  <= 1'b1;
                        state <= LOAD_C;
                    end
                end
                LOAD_C: if (load_done) state <= LOAD_A;
                LOAD_A: if (load_done) state <= LOAD_B;
                LOAD_B: begin
                    if (load_done) begin
                        cnt   <= systolic_time;
                        state <= SYSTOLIC;
                    end
                end
                SYSTOLIC: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0)
                        state <= (job.dtype == INT4) ? ACCUMULATE : WRITE_BACK;
                end
                ACCUMULATE: begin
                    cnt   <= WAIT_WRITE_CYCLES;
                    state <= WAIT_WRITE;
                end
                WAIT_WRITE: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0)
                        state <= WRITE_BACK;
                end
                WRITE_BACK: if (wb_done) state <= FINISH;
                default:    state <= IDLE;  // FINISH
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/tensorcore.sv
`timescale 1ns/1ps
`default_nettype none

module tensorcore (
    input  wire             clk,
    input  wire             rst,
    input  wire             start,
    input  tc_pkg::job_t    job,
    output logic            busy,
    output logic            done,
    output tc_pkg::rd_req_t rd_req,
    output logic            rd_valid,
    input  wire             rd_ready,
    input  wire             rd_finish,
    output tc_pkg::wr_req_t aw,
    output logic            aw_valid,
    input  wire             aw_ready,
    input  wire             b_valid,
    output logic            b_ready
);
    import tc_pkg::*;

    job_t cur_job;  // Latched by the scheduler
    logic load_go;
    mat_t load_mat;
    logic load_done;
    logic wb_go;
    logic wb_done;

    tc_scheduler i_scheduler (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .job_in    (job),
        .busy      (busy),
        .done      (done),
        .job       (cur_job),
        .load_go   (load_go),
        .load_mat  (load_mat),
        .load_done (load_done),
        .wb_go     (wb_go),
        .wb_done   (wb_done)
    );

    rd_issuer i_rd_issuer (
        .clk       (clk),
        .rst       (rst),
        .load_go   (load_go),
        .load_mat  (load_mat),
        .job       (cur_job),
        .load_done (load_done),
        .rd_req    (rd_req),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_finish (rd_finish)
    );

    wb_issuer i_wb_issuer (
        .clk      (clk),
        .rst      (rst),
        .wb_go    (wb_go),
        .job      (cur_job),
        .wb_done  (wb_done),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

`default_nettype wire

// File: bench/tensorcore_props.sv
`timescale 1ns/1ps
`default_nettype none

module tensorcore_props (
    input wire             clk,
    input wire             rst,
    input wire             busy,
    input wire             done,
    input tc_pkg::rd_req_t rd_req,
    input wire             rd_valid,
    input wire             rd_ready,
    input tc_pkg::wr_req_t aw,
    input wire             aw_valid,
    input wire             aw_ready,
    input wire             b_ready
);

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !rd_valid && !aw_valid && !b_ready && !busy && !done)
        else $error("Outputs not idle after reset");

    // Held request must not move until taken
    a_rd_stable: assert property (@(posedge clk) disable iff (rst)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_req))
        else $error("Read request changed before handshake");

    a_aw_stable: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("Write request changed before handshake");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done longer than one cycle");

    a_aw_busy: assert property (@(posedge clk) disable iff (rst) aw_valid |-> busy)
        else $error("aw_valid high while idle");

endmodule

bind tensorcore tensorcore_props i_props (
    .clk      (clk),
    .rst      (rst),
    .busy     (busy),
    .done     (done),
    .rd_req   (rd_req),
    .rd_valid (rd_valid),
    .rd_ready (rd_ready),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .b_ready  (b_ready)
);

`default_nettype wire

// File: bench/tb_tensorcore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tensorcore;
    import tc_pkg::*;

    localparam int TIMEOUT_CYCLES = 24 * 300;

    logic    clk;
    logic    rst;
    logic    start;
    job_t    job;
    logic    busy;
    logic    done;
    rd_req_t rd_req;
    logic    rd_valid;
    logic    rd_ready;
    logic    rd_finish;
    wr_req_t aw;
    logic    aw_valid;
    logic    aw_ready;
    logic    b_valid;
    logic    b_ready;

    logic [31:0] rng = 32'hc375;
    int          cycle = 0;
    int          finish_cycle = 0;  // B burst finished here
    int          rd_count = 0;
    int          aw_count = 0;
    int          done_count = 0;
    logic        job_active = 1'b0;
    logic        aw_prev = 1'b0;
    job_t        exp_job;

    tensorcore i_tensorcore (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .job       (job),
        .busy      (busy),
        .done      (done),
        .rd_req    (rd_req),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_finish (rd_finish),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .b_valid   (b_valid),
        .b_ready   (b_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int draw_below(input int n);
        rng = lcg_next(rng);
        return int'(rng[30:16]) % n;
    endfunction

    // Values listed as FP32, FP16, INT8, INT4
    function automatic int by_type(input dtype_t d, input int fp32, fp16, int8, int4);
        case (d)
            FP32:    return fp32;
            FP16:    return fp16;
            INT8:    return int8;
            default: return int4;
        endcase
    endfunction

    function automatic mat_t load_order(input int i);
        if (i == 0)
            return MAT_C;
        return (i == 1) ? MAT_A : MAT_B;
    endfunction

    function automatic longint base_of(input mat_t m);
        case (m)
            MAT_C:   return 32'h0001_0000;
            MAT_A:   return 32'h0010_0000;
            default: return 32'h0100_0000;
        endcase
    endfunction

    function automatic int burst_num_of(input mat_t m, input job_t j);
        if (m == MAT_C)
            return 31;
        if (m == MAT_A) begin
            case (j.shape)
                M32K16N8:  return by_type(j.dtype, 63, 31, 15, 7);
                M16K16N16: return by_type(j.dtype, 31, 15, 7, 3);
                default:   return by_type(j.dtype, 15, 7, 3, 1);
            endcase
        end
        case (j.shape)
            M32K16N8:  return 15;
            M16K16N16: return by_type(j.dtype, 31, 15, 15, 15);
            default:   return by_type(j.dtype, 63, 31, 15, 15);
        endcase
    endfunction

    function automatic int burst_size_of(input mat_t m, input job_t j);
        if (m == MAT_C)
            return (j.dtype == FP16 && j.mixed) ? 5 : by_type(j.dtype, 5, 4, 3, 2);
        if (m == MAT_A)
            return 5;
        case (j.shape)
            M32K16N8:  return by_type(j.dtype, 5, 4, 3, 2);
            M16K16N16: return by_type(j.dtype, 5, 5, 4, 3);
            default:   return by_type(j.dtype, 5, 5, 5, 4);
        endcase
    endfunction

    // Two cycles from the B finish to SYSTOLIC, then the countdown
    function automatic int write_latency(input job_t j);
        return 3 + by_type(j.dtype, 64, 64, 16, 8) + ((j.dtype == INT4) ? 12 : 0);
    endfunction

    task automatic check_eq(input string name, input longint exp, input longint act);
        assert (exp == act) else begin
            $display("FAILED %s job %0d expected %0d actual %0d", name, done_count, exp, act);
            $display("Some tests failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error in job %0d: %s", done_count, what);
            $display("Some tests failed");
            $fatal(1, "Protocol error");
        end
    endtask

    task automatic run_job(input shape_t s, input dtype_t d, input logic m);
        @(negedge clk);
        job   = '{shape: s, dtype: d, mixed: m};
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done !== 1'b1)
            @(negedge clk);
        repeat (draw_below(3)) @(negedge clk);  // Idle gap between jobs
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("Timeout: no end of the run after %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "Timeout");
        end
        if (!rst) begin
            if (job_active)
                check_true(busy, "busy fell in the middle of a job");
            else
                check_true(!rd_valid && !aw_valid && !b_ready && !busy,
                           "request or busy outside a job");
            if (start && !job_active) begin
                exp_job    = job;
                job_active = 1'b1;
                rd_count   = 0;
                aw_count   = 0;
            end
            if (rd_valid && rd_ready) begin
                check_true(rd_count < 3, "more than three read requests in one job");
                check_eq("read mat", load_order(rd_count), rd_req.mat);
                check_eq("read base", base_of(load_order(rd_count)), rd_req.base);
                check_eq("read burst_num", burst_num_of(load_order(rd_count), exp_job),
                         rd_req.burst_num);
                check_eq("read burst_size", burst_size_of(load_order(rd_count), exp_job),
                         rd_req.burst_size);
                rd_count = rd_count + 1;
            end
            if (rd_finish && rd_count == 3)
                finish_cycle = cycle;
            if (aw_valid && !aw_prev) begin
                check_eq("reads before write", 3, rd_count);
                check_eq("write latency", write_latency(exp_job), cycle - finish_cycle);
                check_eq("write addr", 0, aw.addr);
                check_eq("write len", exp_job.mixed ? 127 : 255, aw.len);
                check_eq("write size", 2, aw.size);
                check_eq("write burst", 1, aw.burst);
            end
            if (aw_valid)
                check_true(!b_ready, "b_ready high before the write address was taken");
            if (b_valid)
                check_true(b_ready, "b_ready low while the write response is offered");
            if (aw_valid && aw_ready)
                aw_count = aw_count + 1;
            if (done) begin
                check_true(job_active, "done without a started job");
                check_eq("write requests", 1, aw_count);
                job_active = 1'b0;
                done_count = done_count + 1;
            end
        end
        aw_prev = aw_valid;
    end

    // Memory side
    initial begin
        forever begin
            @(negedge clk);
            if (rd_valid) begin
                repeat (draw_below(4)) @(negedge clk);
                rd_ready = 1'b1;
                @(negedge clk);
                rd_ready = 1'b0;
                repeat (draw_below(4)) @(negedge clk);
                rd_finish = 1'b1;
                @(negedge clk);
                rd_finish = 1'b0;
            end else if (aw_valid) begin
                repeat (draw_below(4)) @(negedge clk);
                aw_ready = 1'b1;
                @(negedge clk);
                aw_ready = 1'b0;
                repeat (draw_below(3)) @(negedge clk);
                b_valid = 1'b1;
                @(negedge clk);
                b_valid = 1'b0;
            end
        end
    end

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        job       = '0;
        rd_ready  = 1'b0;
        rd_finish = 1'b0;
        aw_ready  = 1'b0;
        b_valid   = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_job(M32K16N8, FP32, 1'b0);
        run_job(M16K16N16, FP16, 1'b1);
        run_job(M8K16N32, INT8, 1'b0);
        run_job(M16K16N16, INT4, 1'b1);
        repeat (20)
            run_job(shape_t'(2'(draw_below(3))), dtype_t'(2'(draw_below(4))),
                    draw_below(2) == 1);
        repeat (3) @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/tc_pkg.sv
hw/burst_table.sv
hw/rd_issuer.sv
hw/wb_issuer.sv
hw/tc_scheduler.sv
hw/tensorcore.sv
bench/tensorcore_props.sv
bench/tb_tensorcore.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_tensorcore -o sim_tensorcore
./obj_dir/sim_tensorcore > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
